// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dcache_top
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
MEM_LATENCY ?= 4
MEM_LINES_LOG2 ?= 8
VFLAGS ?= --timing --assert
PARAMS = -Gmem_latency=$(MEM_LATENCY) -Gmem_lines_log2=$(MEM_LINES_LOG2)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(PARAMS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(PARAMS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    // address split: tag | index | word select | byte offset
    localparam int tag_w = 21;
    localparam int index_w = 5;
    localparam int word_sel_w = 4;
    localparam int data_w = 32;
    localparam int line_w = 512;
    localparam int ways = 2;
    localparam int entry_w = 6;

    // line address toward memory
    localparam int line_addr_w = tag_w + index_w;

    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [tag_w-1:0]       tag;
        logic [index_w-1:0]     index;
        logic [word_sel_w-1:0]  word_sel;
        logic [data_w/8-1:0]    byte_mask;
        logic [data_w-1:0]      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [line_addr_w-1:0] addr;
        logic [line_w-1:0]      wline;
    } mem_req_t;

    typedef struct packed {
        logic                   ready;
        logic [line_w-1:0]      rline;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        COMPARE    = 3'd1,
        WRITE_BACK = 3'd2,
        ALLOCATE   = 3'd3,
        FLUSH      = 3'd4
    } ctrl_state_t;

endpackage

// ==== filelist.f ====
common/dcache_pkg.sv
l1_dcache/l1_dcache_ctrl.sv
l1_dcache/l1_data_array.sv
l1_dcache/l1_dcache.sv
verilog/backing_mem.sv
verilog/dcache_top.sv
verification/tb_dcache_top.sv

// ==== l1_dcache/l1_data_array.sv ====
`timescale 1ns/100ps

module l1_data_array (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic [dcache_pkg::entry_w-1:0]      entry,
    input  logic [dcache_pkg::word_sel_w-1:0]   word_sel,
    input  logic [dcache_pkg::data_w/8-1:0]     byte_mask,
    input  logic [dcache_pkg::data_w-1:0]       wdata,
    input  logic                                word_we,
    input  logic [dcache_pkg::line_w-1:0]       fill_line,
    input  logic                                line_we,
    output logic [dcache_pkg::data_w-1:0]       rdata,
    output logic [dcache_pkg::line_w-1:0]       line
);

    localparam int entries = dcache_pkg::ways << dcache_pkg::index_w;
    localparam int bytes = dcache_pkg::data_w / 8;

    logic [dcache_pkg::line_w-1:0] mem [entries];
    logic [dcache_pkg::line_w-1:0] cur_line;

    assign cur_line = mem[entry];
    assign line = cur_line;
    assign rdata = cur_line[word_sel*dcache_pkg::data_w +: dcache_pkg::data_w];

    always_ff @(posedge clk)
    begin
        if (line_we)
            mem[entry] <= fill_line;
        else if (word_we)
        begin
            // only the enabled byte lanes change
            for (int b = 0; b < bytes; b++)
            begin
                if (byte_mask[b])
                    mem[entry][word_sel*dcache_pkg::data_w + b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    a_we_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(word_we && line_we));

endmodule

// ==== l1_dcache/l1_dcache.sv ====
`timescale 1ns/100ps

module l1_dcache (
    input  logic                            clk,
    input  logic                            nrst,
    input  dcache_pkg::cpu_req_t            req,
    input  logic                            flush,
    output logic                            stall,
    output logic                            done,
    output logic [dcache_pkg::data_w-1:0]   rdata,
    output dcache_pkg::mem_req_t            mem_req,
    input  dcache_pkg::mem_rsp_t            mem_rsp
);

    logic mem_rd;
    logic mem_wr;
    logic word_we;
    logic line_we;
    logic [dcache_pkg::tag_w-1:0] victim_tag;
    logic [dcache_pkg::entry_w-1:0] entry;
    logic [dcache_pkg::index_w-1:0] wb_index;
    logic [dcache_pkg::data_w-1:0] arr_rdata;
    logic [dcache_pkg::line_w-1:0] arr_line;
    logic [dcache_pkg::data_w-1:0] rdata_q;

    l1_dcache_ctrl u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .flush      (flush),
        .mem_ready  (mem_rsp.ready),
        .stall      (stall),
        .done       (done),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .victim_tag (victim_tag),
        .entry      (entry),
        .word_we    (word_we),
        .line_we    (line_we)
    );

    l1_data_array u_data (
        .clk        (clk),
        .nrst       (nrst),
        .entry      (entry),
        .word_sel   (req.word_sel),
        .byte_mask  (req.byte_mask),
        .wdata      (req.wdata),
        .word_we    (word_we),
        .fill_line  (mem_rsp.rline),
        .line_we    (line_we),
        .rdata      (arr_rdata),
        .line       (arr_line)
    );

    // index of the entry being written back, also right during a flush walk
    assign wb_index = entry[dcache_pkg::entry_w-1 -: dcache_pkg::index_w];

    assign mem_req.rd = mem_rd;
    assign mem_req.wr = mem_wr;
    assign mem_req.addr = mem_wr ? {victim_tag, wb_index} : {req.tag, req.index};
    assign mem_req.wline = arr_line;

    // last busy cycle is the compare hit, so rdata holds in the done cycle
    always_ff @(posedge clk)
    begin
        if (stall)
            rdata_q <= arr_rdata;
    end

    assign rdata = rdata_q;

endmodule

// ==== l1_dcache/l1_dcache_ctrl.sv ====
`timescale 1ns/100ps

module l1_dcache_ctrl (
    input  logic                            clk,
    input  logic                            nrst,
    input  dcache_pkg::cpu_req_t            req,
    input  logic                            flush,
    input  logic                            mem_ready,
    output logic                            stall,
    output logic                            done,
    output logic                            mem_rd,
    output logic                            mem_wr,
    output logic [dcache_pkg::tag_w-1:0]    victim_tag,
    output logic [dcache_pkg::entry_w-1:0]  entry,
    output logic                            word_we,
    output logic                            line_we
);

    localparam int entries = dcache_pkg::ways << dcache_pkg::index_w;
    localparam int sets = 1 << dcache_pkg::index_w;

    logic [dcache_pkg::tag_w-1:0] tag_arr [entries];
    logic [entries-1:0] valid;
    logic [entries-1:0] dirty;
    // lru bit names the way to replace next
    logic [sets-1:0] lru;

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t next_state;

    logic [dcache_pkg::entry_w-1:0] flush_idx;
    logic [dcache_pkg::entry_w-1:0] entry0;
    logic [dcache_pkg::entry_w-1:0] entry1;
    logic way_q;
    logic done_q;
    logic hit0;
    logic hit1;
    logic hit;
    logic hit_way;
    logic victim_way;
    logic flush_wb;
    logic flush_last;

    assign entry0 = {req.index, 1'b0};
    assign entry1 = {req.index, 1'b1};

    assign hit0 = valid[entry0] && (tag_arr[entry0] == req.tag);
    assign hit1 = valid[entry1] && (tag_arr[entry1] == req.tag);
    assign hit = hit0 || hit1;
    assign hit_way = hit1;

    // an empty way first, else the lru way
    assign victim_way = !valid[entry0] ? 1'b0 :
                        !valid[entry1] ? 1'b1 : lru[req.index];

    assign flush_wb = valid[flush_idx] && dirty[flush_idx];
    assign flush_last = (flush_idx == '1) && (!flush_wb || mem_ready);

    always_comb
    begin
        case (state)
            dcache_pkg::COMPARE:
                entry = {req.index, hit ? hit_way : victim_way};
            dcache_pkg::WRITE_BACK,
            dcache_pkg::ALLOCATE:
                entry = {req.index, way_q};
            dcache_pkg::FLUSH:
                entry = flush_idx;
            default:
                entry = entry0;
        endcase
    end

    assign stall = (state != dcache_pkg::IDLE);
    assign done = done_q;
    assign mem_rd = (state == dcache_pkg::ALLOCATE);
    assign mem_wr = (state == dcache_pkg::WRITE_BACK) ||
                    ((state == dcache_pkg::FLUSH) && flush_wb);
    assign word_we = (state == dcache_pkg::COMPARE) && hit && req.wr;
    assign line_we = (state == dcache_pkg::ALLOCATE) && mem_ready;
    assign victim_tag = tag_arr[entry];

    always_comb
    begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE:
            begin
                // hold off in the done cycle, the cpu still drives the old request
                if (!done_q && (req.rd || req.wr))
                    next_state = dcache_pkg::COMPARE;
                else if (!done_q && flush)
                    next_state = dcache_pkg::FLUSH;
            end
            dcache_pkg::COMPARE:
            begin
                if (hit)
                    next_state = dcache_pkg::IDLE;
                else if (valid[entry] && dirty[entry])
                    next_state = dcache_pkg::WRITE_BACK;
                else
                    next_state = dcache_pkg::ALLOCATE;
            end
            dcache_pkg::WRITE_BACK:
            begin
                if (mem_ready)
                    next_state = dcache_pkg::ALLOCATE;
            end
            dcache_pkg::ALLOCATE:
            begin
                if (mem_ready)
                    next_state = dcache_pkg::COMPARE;
            end
            dcache_pkg::FLUSH:
            begin
                if (flush_last)
                    next_state = dcache_pkg::IDLE;
            end
            default:
                next_state = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= dcache_pkg::IDLE;
            done_q <= 1'b0;
            way_q <= 1'b0;
            flush_idx <= '0;
        end
        else
        begin
            state <= next_state;
            done_q <= ((state == dcache_pkg::COMPARE) && hit) ||
                      ((state == dcache_pkg::FLUSH) && flush_last);
            if ((state == dcache_pkg::COMPARE) && !hit)
                way_q <= victim_way;
            // walk one entry per cycle, wait on ready for dirty ones
            if (state == dcache_pkg::FLUSH)
            begin
                if (!flush_wb || mem_ready)
                    flush_idx <= flush_idx + 1'b1;
            end
            else
                flush_idx <= '0;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end
        else if ((state == dcache_pkg::FLUSH) && flush_last)
        begin
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end
        else
        begin
            if (line_we)
            begin
                valid[entry] <= 1'b1;
                dirty[entry] <= 1'b0;
            end
            if (word_we)
                dirty[entry] <= 1'b1;
            if ((state == dcache_pkg::COMPARE) && hit)
                lru[req.index] <= ~hit_way;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line_we)
            tag_arr[entry] <= req.tag;
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_rd && mem_wr));

    a_done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        done |=> !done);

    a_state_legal: assert property (@(posedge clk) disable iff (!nrst)
        state inside {dcache_pkg::IDLE, dcache_pkg::COMPARE, dcache_pkg::WRITE_BACK,
                      dcache_pkg::ALLOCATE, dcache_pkg::FLUSH});

endmodule

// ==== verification/tb_dcache_top.sv ====
`timescale 1ns/100ps

module tb_dcache_top #(
    parameter int mem_latency = 4,
    parameter int mem_lines_log2 = 8
);

    localparam int seed = 32'h04af12df;
    localparam int n_random = 400;
    localparam int n_sweep = 512;
    localparam int n_access = 2 * n_sweep + n_random + 8;
    localparam int n_flush = 10;
    localparam int timeout_cycles = n_access * (2 * mem_latency + 6) +
                                    n_flush * 64 * (mem_latency + 2) + 1000;

    // edges from the first sampling edge to the edge before done is seen
    localparam int hit_lat = 2;
    localparam int clean_miss_lat = mem_latency + 4;
    localparam int dirty_miss_lat = 2 * mem_latency + 5;

    logic clk;
    logic nrst;
    dcache_pkg::cpu_req_t req;
    logic flush;
    logic stall;
    logic done;
    logic [dcache_pkg::data_w-1:0] rdata;

    // word image for tags 0..7, 32 sets, 16 words
    logic [dcache_pkg::data_w-1:0] model_mem [4096];
    // mirror of the cache tags
    bit m_valid [32][2];
    bit m_dirty [32][2];
    int m_tag [32][2];
    bit m_lru [32];
    int cycle_cnt = 0;

    dcache_top #(
        .mem_latency    (mem_latency),
        .mem_lines_log2 (mem_lines_log2)
    ) dut (
        .clk    (clk),
        .nrst   (nrst),
        .req    (req),
        .flush  (flush),
        .stall  (stall),
        .done   (done),
        .rdata  (rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles)
        begin
            $display("run went past %0d cycles, an access never finished", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_word(input string name, input logic [dcache_pkg::data_w-1:0] exp,
                                input logic [dcache_pkg::data_w-1:0] act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp)
        begin
            $display("ERR %s latency expected %0d actual %0d", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "control bit mismatch");
        end
    endtask

    // steps the tag mirror for one access
    task automatic predict_latency(input int tag, input int idx, input bit wr, output int lat);
        int way;
        way = -1;
        if (m_valid[idx][0] && m_tag[idx][0] == tag)
            way = 0;
        else if (m_valid[idx][1] && m_tag[idx][1] == tag)
            way = 1;
        if (way >= 0)
            lat = hit_lat;
        else
        begin
            // free way first, else the lru way
            if (!m_valid[idx][0])
                way = 0;
            else if (!m_valid[idx][1])
                way = 1;
            else
                way = m_lru[idx] ? 1 : 0;
            lat = (m_valid[idx][way] && m_dirty[idx][way]) ? dirty_miss_lat : clean_miss_lat;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way] = tag;
        end
        m_lru[idx] = (way == 0);
        if (wr)
            m_dirty[idx][way] = 1'b1;
    endtask

    task automatic wait_for_done(input string name, output int lat);
        lat = 0;
        do
        begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            // busy until the done cycle
            expect_bit({name, " stall"}, !done, stall);
        end
        while (!done);
    endtask

    task automatic cpu_access(input string name, input bit wr, input int tag, input int idx,
                              input int word, input logic [3:0] mask,
                              input logic [dcache_pkg::data_w-1:0] wdata);
        int exp_lat;
        int lat;
        int addr;
        int b;
        string tname;
        predict_latency(tag, idx, wr, exp_lat);
        addr = tag * 512 + idx * 16 + word;
        tname = $sformatf("%s t%0d s%0d w%0d", name, tag, idx, word);
        @(posedge clk);
        #2;
        req.rd = !wr;
        req.wr = wr;
        req.tag = tag[dcache_pkg::tag_w-1:0];
        req.index = idx[dcache_pkg::index_w-1:0];
        req.word_sel = word[dcache_pkg::word_sel_w-1:0];
        req.byte_mask = mask;
        req.wdata = wdata;
        wait_for_done(tname, lat);
        check_latency(tname, exp_lat, lat);
        if (wr)
        begin
            for (b = 0; b < 4; b++)
            begin
                if (mask[b])
                    model_mem[addr][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        else
            compare_word(tname, model_mem[addr], rdata);
    endtask

    task automatic flush_cache();
        int s;
        @(posedge clk);
        #2;
        req.rd = 1'b0;
        req.wr = 1'b0;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        while (!done)
            @(negedge clk);
        for (s = 0; s < 32; s++)
        begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s] = 1'b0;
        end
    endtask

    // every word of the lines that the random accesses can touch
    task automatic read_region(input string name);
        int t;
        int s;
        int w;
        for (t = 0; t < 8; t++)
            for (s = 0; s < 4; s++)
                for (w = 0; w < 16; w++)
                    cpu_access(name, 1'b0, t, s, w, 4'h0, '0);
    endtask

    initial
    begin
        int i;
        int tag;
        int idx;
        int word;
        bit wr;
        logic [3:0] mask;
        void'($urandom(seed));
        nrst = 1'b0;
        req = '0;
        flush = 1'b0;
        for (i = 0; i < 4096; i++)
            model_mem[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        nrst = 1'b1;
        @(negedge clk);
        expect_bit("reset stall", 1'b0, stall);
        expect_bit("reset done", 1'b0, done);
        read_region("reset read");

        // set 2 takes A then B, then C evicts dirty A and B still hits
        flush_cache();
        cpu_access("lru write A", 1'b1, 1, 2, 3, 4'hf, 32'h1234abcd);
        cpu_access("lru write B", 1'b1, 2, 2, 5, 4'h5, 32'h5a5a0f0f);
        cpu_access("lru read C", 1'b0, 3, 2, 3, 4'h0, '0);
        cpu_access("lru read B", 1'b0, 2, 2, 5, 4'h0, '0);
        cpu_access("lru read A", 1'b0, 1, 2, 3, 4'h0, '0);

        for (i = 0; i < n_random; i++)
        begin
            if (i % 60 == 59)
                flush_cache();
            tag = $urandom_range(7, 0);
            idx = $urandom_range(3, 0);
            word = $urandom_range(15, 0);
            wr = ($urandom_range(1, 0) == 1);
            mask = 4'($urandom_range(15, 1));
            cpu_access("random", wr, tag, idx, word, mask, $urandom());
        end

        flush_cache();
        read_region("after flush");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog/backing_mem.sv ====
`timescale 1ns/100ps

module backing_mem #(
    parameter int mem_latency = 4,
    parameter int mem_lines_log2 = 8
) (
    input  logic                    clk,
    input  logic                    nrst,
    input  dcache_pkg::mem_req_t    mem_req,
    output dcache_pkg::mem_rsp_t    mem_rsp
);

    localparam int cnt_w = $clog2(mem_latency + 1);
    localparam int lines = 1 << mem_lines_log2;

    logic [dcache_pkg::line_w-1:0] mem [lines] = '{default: '0};

    logic busy;
    logic [cnt_w-1:0] cnt;
    logic [mem_lines_log2-1:0] line_idx;
    logic ready;

    // upper line address bits are dropped
    assign line_idx = mem_req.addr[mem_lines_log2-1:0];

    assign ready = busy && (cnt == cnt_w'(mem_latency));
    assign mem_rsp.ready = ready;
    assign mem_rsp.rline = mem[line_idx];

    // cnt reaches mem_latency that many cycles after the strobe is first seen
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            busy <= 1'b0;
            cnt <= '0;
        end
        else if (!busy)
        begin
            if (mem_req.rd || mem_req.wr)
            begin
                busy <= 1'b1;
                cnt <= cnt_w'(1);
            end
        end
        else if (ready)
        begin
            busy <= 1'b0;
            cnt <= '0;
        end
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (ready && mem_req.wr)
            mem[line_idx] <= mem_req.wline;
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!nrst)
        (mem_req.rd || mem_req.wr) && !ready |=> $stable(mem_req.addr));

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top #(
    parameter int mem_latency = 4,
    parameter int mem_lines_log2 = 8
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  dcache_pkg::cpu_req_t            req,
    input  logic                            flush,
    output logic                            stall,
    output logic                            done,
    output logic [dcache_pkg::data_w-1:0]   rdata
);

    dcache_pkg::mem_req_t mem_req;
    dcache_pkg::mem_rsp_t mem_rsp;

    l1_dcache u_cache (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .flush      (flush),
        .stall      (stall),
        .done       (done),
        .rdata      (rdata),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    backing_mem #(
        .mem_latency    (mem_latency),
        .mem_lines_log2 (mem_lines_log2)
    ) u_mem (
        .clk        (clk),
        .nrst       (nrst),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

endmodule
